/* common/decode_pkg.sv */
package decode_pkg;

  localparam int lanes = 2;           // Instructions per bundle
  localparam int xlen = 32;
  localparam int ilen = 32;
  localparam int bundle_width = lanes * ilen;
  localparam int bundle_bytes = bundle_width / 8;

  localparam logic [xlen-1:0] reset_pc = 32'h0000_1000;

  typedef logic [4:0] reg_addr_t;

  typedef enum logic [3:0] {
    class_nop,
    class_alu,
    class_alu_imm,
    class_lui,
    class_auipc,
    class_jal,
    class_jalr,
    class_branch,
    class_load,
    class_store
  } op_class_t;

  // RV32I major opcodes
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;

  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } r_view_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_view_t;

  // Same word, register layout or split store/branch immediate
  typedef union packed {
    r_view_t r;
    s_view_t s;
  } instr_word_t;

endpackage

/* src/fetch/fetch_unit.sv */
module fetch_unit (
  input  logic                               clock,
  input  logic                               reset,
  input  logic                               halt,
  input  logic                               clear,
  input  logic [decode_pkg::xlen-1:0]         redirect_pc,
  input  logic [decode_pkg::bundle_width-1:0] wb_dat_i,
  input  logic                               wb_ack,
  output logic                               wb_cyc,
  output logic                               wb_stb,
  output logic                               wb_we,
  output logic [decode_pkg::xlen-1:0]         wb_adr,
  output logic                               bundle_valid,
  output logic [decode_pkg::xlen-1:0]         bundle_pc,
  output logic [decode_pkg::bundle_width-1:0] bundle_data
);
  import decode_pkg::*;

  logic            busy;  // Bus cycle outstanding
  logic            drop;  // Cycle was redirected, discard its data
  logic            done;
  logic            start;
  logic [xlen-1:0] pc;

  assign done  = busy && wb_ack;
  assign start = !busy && !halt;

  assign wb_cyc = busy;
  assign wb_stb = busy;
  assign wb_we  = 1'b0;  // Read only master

  always_ff @(posedge clock) begin
    if (!reset) begin
      busy         <= 1'b0;
      drop         <= 1'b0;
      bundle_valid <= 1'b0;
      pc           <= reset_pc;
      wb_adr       <= reset_pc;
    end else begin
      bundle_valid <= done && !drop && !clear;

      if (start) begin
        busy   <= 1'b1;
        wb_adr <= clear ? redirect_pc : pc;  // Redirect takes effect at once
      end else if (done) begin
        busy <= 1'b0;
      end

      if (done) begin
        drop <= 1'b0;
      end else if (clear && busy) begin
        drop <= 1'b1;
      end

      if (clear) begin
        pc <= redirect_pc;
      end else if (done && !drop) begin
        pc <= pc + xlen'(bundle_bytes);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (done) begin
      bundle_data <= wb_dat_i;
      bundle_pc   <= wb_adr;
    end
  end

  // Wishbone classic rules for the master side
  assert property (@(posedge clock) disable iff (!reset) wb_stb |-> wb_cyc);

  assert property (@(posedge clock) disable iff (!reset)
    wb_stb && !wb_ack |=> $stable(wb_adr));

endmodule

/* src/decode/lane_decoder.sv */
module lane_decoder #(
  parameter int lane_index = 0
) (
  input  decode_pkg::instr_word_t     instr,
  input  logic [decode_pkg::xlen-1:0] bundle_pc,
  output logic [decode_pkg::xlen-1:0] pc,
  output decode_pkg::reg_addr_t       waddr,
  output decode_pkg::reg_addr_t       raddr1,
  output decode_pkg::reg_addr_t       raddr2,
  output logic [decode_pkg::xlen-1:0] imm,
  output decode_pkg::op_class_t       op_class,
  output logic                        wren,
  output logic                        rden1,
  output logic                        rden2,
  output logic                        exception
);
  import decode_pkg::*;

  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_s;
  logic [xlen-1:0] imm_b;
  logic [xlen-1:0] imm_u;
  logic [xlen-1:0] imm_j;
  logic            wr;
  logic            rd1;
  logic            rd2;

  assign pc = bundle_pc + xlen'(4 * lane_index);  // Slot offset inside bundle

  // Immediate formats
  assign imm_i = {{20{instr.r.funct7[6]}}, instr.r.funct7, instr.r.rs2};
  assign imm_s = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
  assign imm_b = {{19{instr.s.imm_hi[6]}}, instr.s.imm_hi[6], instr.s.imm_lo[0],
                  instr.s.imm_hi[5:0], instr.s.imm_lo[4:1], 1'b0};
  assign imm_u = {instr.r.funct7, instr.r.rs2, instr.r.rs1, instr.r.funct3, 12'b0};
  assign imm_j = {{12{instr.r.funct7[6]}}, instr.r.rs1, instr.r.funct3, instr.r.rs2[0],
                  instr.r.funct7[5:0], instr.r.rs2[4:1], 1'b0};

  always_comb begin
    op_class  = class_nop;
    imm       = '0;
    wr        = 1'b0;
    rd1       = 1'b0;
    rd2       = 1'b0;
    exception = 1'b0;
    case (instr.r.opcode)
      op_reg: begin
        op_class = class_alu;
        {wr, rd1, rd2} = 3'b111;
      end
      op_imm: begin
        op_class = class_alu_imm;
        imm      = imm_i;
        {wr, rd1} = 2'b11;
      end
      op_lui: begin
        op_class = class_lui;
        imm      = imm_u;
        wr       = 1'b1;
      end
      op_auipc: begin
        op_class = class_auipc;
        imm      = imm_u;
        wr       = 1'b1;
      end
      op_jal: begin
        op_class = class_jal;
        imm      = imm_j;
        wr       = 1'b1;
      end
      op_jalr: begin
        op_class  = class_jalr;
        imm       = imm_i;
        {wr, rd1} = 2'b11;
        exception = instr.r.funct3 != 3'b000;
      end
      op_branch: begin
        op_class   = class_branch;
        imm        = imm_b;
        {rd1, rd2} = 2'b11;
        exception  = instr.r.funct3[2:1] == 2'b01;  // funct3 2 and 3 unused
      end
      op_load: begin
        op_class  = class_load;
        imm       = imm_i;
        {wr, rd1} = 2'b11;
        exception = instr.r.funct3 == 3'b011 || instr.r.funct3[2:1] == 2'b11;
      end
      op_store: begin
        op_class   = class_store;
        imm        = imm_s;
        {rd1, rd2} = 2'b11;
        exception  = instr.r.funct3 > 3'b010;  // Only sb, sh, sw
      end
      default: exception = 1'b1;
    endcase
    if (exception) begin
      op_class = class_nop;
      imm      = '0;
      wr       = 1'b0;
      rd1      = 1'b0;
      rd2      = 1'b0;
    end
  end

  assign wren   = wr && (instr.r.rd != '0);  // x0 is never written
  assign rden1  = rd1;
  assign rden2  = rd2;
  assign waddr  = wren ? instr.r.rd : '0;
  assign raddr1 = rd1 ? instr.r.rs1 : '0;
  assign raddr2 = rd2 ? instr.r.rs2 : '0;

endmodule

/* src/decode/decode_register.sv */
module decode_register (
  input  logic                                         clock,
  input  logic                                         reset,
  input  logic                                         clear,
  input  logic                                         halt,
  input  logic                                         bundle_valid,
  input  logic [decode_pkg::lanes-1:0][decode_pkg::xlen-1:0] lane_pc,
  input  decode_pkg::reg_addr_t [decode_pkg::lanes-1:0]  lane_waddr,
  input  decode_pkg::reg_addr_t [decode_pkg::lanes-1:0]  lane_raddr1,
  input  decode_pkg::reg_addr_t [decode_pkg::lanes-1:0]  lane_raddr2,
  input  logic [decode_pkg::lanes-1:0][decode_pkg::xlen-1:0] lane_imm,
  input  decode_pkg::op_class_t [decode_pkg::lanes-1:0]  lane_class,
  input  logic [decode_pkg::lanes-1:0]                  lane_wren,
  input  logic [decode_pkg::lanes-1:0]                  lane_rden1,
  input  logic [decode_pkg::lanes-1:0]                  lane_rden2,
  input  logic [decode_pkg::lanes-1:0]                  lane_exception,
  output logic [decode_pkg::lanes-1:0]                  out_valid,
  output logic [decode_pkg::lanes-1:0][decode_pkg::xlen-1:0] out_pc,
  output decode_pkg::reg_addr_t [decode_pkg::lanes-1:0]  out_waddr,
  output decode_pkg::reg_addr_t [decode_pkg::lanes-1:0]  out_raddr1,
  output decode_pkg::reg_addr_t [decode_pkg::lanes-1:0]  out_raddr2,
  output logic [decode_pkg::lanes-1:0][decode_pkg::xlen-1:0] out_imm,
  output decode_pkg::op_class_t [decode_pkg::lanes-1:0]  out_class,
  output logic [decode_pkg::lanes-1:0]                  out_wren,
  output logic [decode_pkg::lanes-1:0]                  out_rden1,
  output logic [decode_pkg::lanes-1:0]                  out_rden2,
  output logic [decode_pkg::lanes-1:0]                  out_exception
);
  import decode_pkg::*;

  logic bubble;

  assign bubble = clear || halt || !bundle_valid;  // Clear beats an arriving bundle

  always_ff @(posedge clock) begin
    if (!reset || bubble) begin
      out_valid     <= '0;
      out_pc        <= '0;
      out_waddr     <= '0;
      out_raddr1    <= '0;
      out_raddr2    <= '0;
      out_imm       <= '0;
      out_wren      <= '0;
      out_rden1     <= '0;
      out_rden2     <= '0;
      out_exception <= '0;
      for (int i = 0; i < lanes; i++) begin
        out_class[i] <= class_nop;
      end
    end else begin
      out_valid     <= {lanes{1'b1}};
      out_pc        <= lane_pc;
      out_waddr     <= lane_waddr;
      out_raddr1    <= lane_raddr1;
      out_raddr2    <= lane_raddr2;
      out_imm       <= lane_imm;
      out_class     <= lane_class;
      out_wren      <= lane_wren;
      out_rden1     <= lane_rden1;
      out_rden2     <= lane_rden2;
      out_exception <= lane_exception;
    end
  end

  assert property (@(posedge clock) disable iff (!reset) clear |=> out_valid == '0);

endmodule

/* src/decode_top.sv */
module decode_top (
  input  logic                                         clock,
  input  logic                                         reset,
  input  logic                                         halt,
  input  logic                                         clear,
  input  logic [decode_pkg::xlen-1:0]                   redirect_pc,
  input  logic [decode_pkg::bundle_width-1:0]           wb_dat_i,
  input  logic                                         wb_ack,
  output logic                                         wb_cyc,
  output logic                                         wb_stb,
  output logic                                         wb_we,
  output logic [decode_pkg::xlen-1:0]                   wb_adr,
  output logic [decode_pkg::lanes-1:0]                  out_valid,
  output logic [decode_pkg::lanes-1:0][decode_pkg::xlen-1:0] out_pc,
  output decode_pkg::reg_addr_t [decode_pkg::lanes-1:0]  out_waddr,
  output decode_pkg::reg_addr_t [decode_pkg::lanes-1:0]  out_raddr1,
  output decode_pkg::reg_addr_t [decode_pkg::lanes-1:0]  out_raddr2,
  output logic [decode_pkg::lanes-1:0][decode_pkg::xlen-1:0] out_imm,
  output decode_pkg::op_class_t [decode_pkg::lanes-1:0]  out_class,
  output logic [decode_pkg::lanes-1:0]                  out_wren,
  output logic [decode_pkg::lanes-1:0]                  out_rden1,
  output logic [decode_pkg::lanes-1:0]                  out_rden2,
  output logic [decode_pkg::lanes-1:0]                  out_exception
);
  import decode_pkg::*;

  logic                          bundle_valid;
  logic [xlen-1:0]               bundle_pc;
  logic [bundle_width-1:0]       bundle_data;
  logic [lanes-1:0][xlen-1:0]    lane_pc;
  logic [lanes-1:0][xlen-1:0]    lane_imm;
  reg_addr_t [lanes-1:0]         lane_waddr;
  reg_addr_t [lanes-1:0]         lane_raddr1;
  reg_addr_t [lanes-1:0]         lane_raddr2;
  op_class_t [lanes-1:0]         lane_class;
  logic [lanes-1:0]              lane_wren;
  logic [lanes-1:0]              lane_rden1;
  logic [lanes-1:0]              lane_rden2;
  logic [lanes-1:0]              lane_exception;

  fetch_unit u_fetch (
    .clock, .reset, .halt, .clear, .redirect_pc,
    .wb_dat_i, .wb_ack, .wb_cyc, .wb_stb, .wb_we, .wb_adr,
    .bundle_valid, .bundle_pc, .bundle_data
  );

  // Lane i decodes slot i of the bundle
  for (genvar i = 0; i < lanes; i++) begin : g_lane
    lane_decoder #(.lane_index(i)) u_lane (
      .instr     (bundle_data[i*ilen +: ilen]),
      .bundle_pc (bundle_pc),
      .pc        (lane_pc[i]),
      .waddr     (lane_waddr[i]),
      .raddr1    (lane_raddr1[i]),
      .raddr2    (lane_raddr2[i]),
      .imm       (lane_imm[i]),
      .op_class  (lane_class[i]),
      .wren      (lane_wren[i]),
      .rden1     (lane_rden1[i]),
      .rden2     (lane_rden2[i]),
      .exception (lane_exception[i])
    );
  end

  decode_register u_decode_reg (
    .clock, .reset, .clear, .halt, .bundle_valid,
    .lane_pc, .lane_waddr, .lane_raddr1, .lane_raddr2, .lane_imm, .lane_class,
    .lane_wren, .lane_rden1, .lane_rden2, .lane_exception,
    .out_valid, .out_pc, .out_waddr, .out_raddr1, .out_raddr2, .out_imm, .out_class,
    .out_wren, .out_rden1, .out_rden2, .out_exception
  );

endmodule

/* bench/instr_mem_model.sv */
module instr_mem_model (
  input  logic        clock,
  input  logic        reset,
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  logic [31:0] wb_adr,
  input  logic [1:0]  ack_delay,  // Wait states, 1 to 3
  output logic [63:0] wb_dat_o,
  output logic        wb_ack
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [63:0] mem [0:1023];  // 8 KB of bundles, loaded from the testbench
  logic [1:0]  count;

  always @(posedge clock) begin
    if (!reset) begin
      wb_ack   <= 1'b0;
      count    <= '0;
      wb_dat_o <= '0;
    end else if (wb_cyc && wb_stb && !wb_we && !wb_ack) begin
      if (count == ack_delay) begin
        wb_ack   <= 1'b1;
        wb_dat_o <= mem[wb_adr[12:3]];
        count    <= '0;
      end else begin
        count <= count + 2'd1;
      end
    end else begin
      wb_ack <= 1'b0;  // Ack lasts one cycle
    end
  end

endmodule

/* bench/tb_decode_top.sv */
module tb_decode_top;
  timeunit 1ns;
  timeprecision 1ps;
  import decode_pkg::*;

  typedef struct packed {
    logic [xlen-1:0] pc;
    reg_addr_t       waddr;
    reg_addr_t       raddr1;
    reg_addr_t       raddr2;
    logic [xlen-1:0] imm;
    op_class_t       cls;
    logic            wren;
    logic            rden1;
    logic            rden2;
    logic            exc;
  } decoded_t;

  localparam int format_bundles = 10;
  localparam int pc_bundles = 8;
  localparam int random_bundles = 64;
  // Redirect and halt cost about 4 and 8 bundle times
  localparam int bundle_total = format_bundles + 1 + pc_bundles + 4 + 8 + random_bundles;
  localparam int timeout_ns = bundle_total * 6 * 100 + 20000;

  logic clock = 1'b0;
  logic reset;
  logic halt;
  logic clear;
  logic [xlen-1:0] redirect_pc;
  logic [1:0] ack_delay;
  logic [bundle_width-1:0] wb_dat_i;
  logic wb_ack, wb_cyc, wb_stb, wb_we;
  logic [xlen-1:0] wb_adr;
  logic [lanes-1:0] out_valid, out_wren, out_rden1, out_rden2, out_exception;
  logic [lanes-1:0][xlen-1:0] out_pc, out_imm;
  reg_addr_t [lanes-1:0] out_waddr, out_raddr1, out_raddr2;
  op_class_t [lanes-1:0] out_class;

  logic [31:0] lfsr_state = 32'h9339_6015;
  logic [63:0] image [0:1023];
  decoded_t obs_q [$];
  logic [xlen-1:0] expect_pc;
  logic last_ack;
  logic ack_before_last;

  decode_top dut0 (.*);

  instr_mem_model mem0 (
    .clock, .reset, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .ack_delay,
    .wb_dat_o(wb_dat_i), .wb_ack
  );

  always #50 clock = ~clock;

  function automatic logic [31:0] random_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  // RV32I field rules, written from the instruction formats
  function automatic decoded_t ref_decode(logic [31:0] w, logic [xlen-1:0] pc);
    decoded_t d;
    logic wr, r1, r2;
    d = '0;
    wr = 0;
    r1 = 0;
    r2 = 0;
    d.cls = class_nop;
    case (w[6:0])
      7'b0110011: begin
        d.cls = class_alu;
        {wr, r1, r2} = 3'b111;
      end
      7'b0010011: begin
        d.cls = class_alu_imm;
        d.imm = {{20{w[31]}}, w[31:20]};
        {wr, r1} = 2'b11;
      end
      7'b0110111: begin
        d.cls = class_lui;
        d.imm = {w[31:12], 12'b0};
        wr = 1;
      end
      7'b0010111: begin
        d.cls = class_auipc;
        d.imm = {w[31:12], 12'b0};
        wr = 1;
      end
      7'b1101111: begin
        d.cls = class_jal;
        d.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        wr = 1;
      end
      7'b1100111: begin
        d.cls = class_jalr;
        d.imm = {{20{w[31]}}, w[31:20]};
        {wr, r1} = 2'b11;
        d.exc = w[14:12] != 3'd0;
      end
      7'b1100011: begin
        d.cls = class_branch;
        d.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        {r1, r2} = 2'b11;
        d.exc = w[14:12] == 3'd2 || w[14:12] == 3'd3;
      end
      7'b0000011: begin
        d.cls = class_load;
        d.imm = {{20{w[31]}}, w[31:20]};
        {wr, r1} = 2'b11;
        d.exc = w[14:12] == 3'd3 || w[14:12] >= 3'd6;
      end
      7'b0100011: begin
        d.cls = class_store;
        d.imm = {{20{w[31]}}, w[31:25], w[11:7]};
        {r1, r2} = 2'b11;
        d.exc = w[14:12] > 3'd2;
      end
      default: d.exc = 1;
    endcase
    if (d.exc) begin
      d = '0;
      d.cls = class_nop;
      d.exc = 1;
    end else begin
      d.wren = wr && w[11:7] != 5'd0;
      d.rden1 = r1;
      d.rden2 = r2;
      d.waddr = d.wren ? w[11:7] : 5'd0;
      d.raddr1 = r1 ? w[19:15] : 5'd0;
      d.raddr2 = r2 ? w[24:20] : 5'd0;
    end
    d.pc = pc;
    return d;
  endfunction

  task automatic stop_with_failure();
    $display("RESULT: FAIL");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic report_mismatch(string what, logic [xlen-1:0] got, logic [xlen-1:0] exp);
    $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
    stop_with_failure();
  endtask

  task automatic check_word(string what, logic [xlen-1:0] got, logic [xlen-1:0] exp);
    if (got !== exp) report_mismatch(what, got, exp);
  endtask

  task automatic check_reg(string what, reg_addr_t got, reg_addr_t exp);
    if (got !== exp) report_mismatch(what, xlen'(got), xlen'(exp));
  endtask

  task automatic check_class(string what, op_class_t got, op_class_t exp);
    if (got !== exp) report_mismatch(what, xlen'(got), xlen'(exp));
  endtask

  task automatic check_bit(string what, logic got, logic exp);
    if (got !== exp) report_mismatch(what, xlen'(got), xlen'(exp));
  endtask

  // Sample output lanes mid cycle
  always @(negedge clock) begin
    ack_before_last <= last_ack;
    last_ack <= wb_ack;
    if (reset) begin
      check_bit("wb_we", wb_we, 1'b0);  // Read only bus
    end
    if (reset && out_valid != '0) begin
      check_bit("wb_ack two cycles before out_valid", ack_before_last, 1'b1);
      for (int l = 0; l < lanes; l++) begin
        check_bit("out_valid", out_valid[l], 1'b1);
        obs_q.push_back('{out_pc[l], out_waddr[l], out_raddr1[l], out_raddr2[l], out_imm[l],
                          out_class[l], out_wren[l], out_rden1[l], out_rden2[l],
                          out_exception[l]});
      end
    end
  end

  always @(posedge clock) begin
    #10 ack_delay <= 2'd1 + 2'(random_bits(2) % 3);
  end

  task automatic check_bundle();
    decoded_t got, exp;
    logic [63:0] b;
    b = image[expect_pc[12:3]];
    for (int l = 0; l < lanes; l++) begin
      while (obs_q.size() == 0) @(negedge clock);
      got = obs_q.pop_front();
      exp = ref_decode(b[l*32 +: 32], expect_pc + 4 * l);
      check_word("out_pc", got.pc, exp.pc);
      check_reg("out_waddr", got.waddr, exp.waddr);
      check_reg("out_raddr1", got.raddr1, exp.raddr1);
      check_reg("out_raddr2", got.raddr2, exp.raddr2);
      check_word("out_imm", got.imm, exp.imm);
      check_class("out_class", got.cls, exp.cls);
      check_bit("out_wren", got.wren, exp.wren);
      check_bit("out_rden1", got.rden1, exp.rden1);
      check_bit("out_rden2", got.rden2, exp.rden2);
      check_bit("out_exception", got.exc, exp.exc);
    end
    expect_pc += 8;
  endtask

  task automatic decode_formats();
    repeat (format_bundles) check_bundle();
  endtask

  task automatic flag_illegal();
    decoded_t lane_out;
    while (obs_q.size() == 0) @(negedge clock);
    for (int l = 0; l < lanes; l++) begin
      lane_out = obs_q[l];
      check_class("illegal class", lane_out.cls, class_nop);
      check_bit("illegal exception", lane_out.exc, 1'b1);
    end
    check_bundle();
  endtask

  task automatic walk_pc_sequence();
    repeat (pc_bundles) check_bundle();
  endtask

  task automatic redirect_mid_cycle();
    do begin
      @(posedge clock);
      #10;
    end while (!(wb_cyc && !wb_ack));
    clear = 1'b1;
    redirect_pc = 32'h0000_1800;
    @(posedge clock);
    #10 clear = 1'b0;
    check_bit("out_valid after clear", out_valid[0], 1'b0);
    check_bit("out_valid after clear", out_valid[1], 1'b0);
    obs_q.delete();  // Bundles from before the redirect
    expect_pc = 32'h0000_1800;
    repeat (2) check_bundle();
  endtask

  task automatic hold_with_halt();
    int n0, window_valids, dropped;
    logic prev_stb;
    @(posedge clock);
    #10;
    n0 = obs_q.size();
    dropped = last_ack;  // Bundle handed over during the first halt cycle
    window_valids = 0;
    prev_stb = wb_stb;
    halt = 1'b1;
    for (int k = 0; k < 12; k++) begin
      @(negedge clock);
      if (out_valid[0]) window_valids++;
      if (wb_ack && k < 11) dropped++;
      if (wb_stb && !prev_stb) begin
        $display("Error at %0t: a new bus cycle started while halt was held", $time);
        stop_with_failure();
      end
      prev_stb = wb_stb;
    end
    check_bit("at most one bundle under halt", window_valids > 1, 1'b0);
    @(posedge clock);
    #10 halt = 1'b0;
    repeat (n0 / lanes + window_valids) check_bundle();
    expect_pc += 8 * dropped;
    repeat (3) check_bundle();
  endtask

  task automatic decode_random();
    repeat (random_bundles) check_bundle();
  endtask

  initial begin
    #(timeout_ns);
    $display("Timeout: the tests did not finish in %0d ns", timeout_ns);
    stop_with_failure();
  end

  initial begin
    reset = 1'b0;
    halt = 1'b0;
    clear = 1'b0;
    redirect_pc = '0;
    ack_delay = 2'd1;
    for (int i = 0; i < 1024; i++) image[i] = {random_bits(32), random_bits(32)};
    image[512] = {32'hFFD30293, 32'h002081B3};  // addi, add
    image[513] = {32'hABCDE417, 32'h123453B7};  // auipc, lui
    image[514] = {32'h00408067, 32'hFF9FF0EF};  // jalr to x0, jal
    image[515] = {32'h00C12483, 32'hFE208EE3};  // lw, beq
    image[516] = {32'h00208033, 32'hFE552623};  // add to x0, sw
    for (int i = 0; i < 5; i++) begin  // Same words with the lanes swapped
      image[517 + i] = {image[512 + i][31:0], image[512 + i][63:32]};
    end
    image[522] = {32'hFE20AEE3, 32'hFFFFFFFF};  // Bad branch funct3, undefined opcode
    for (int i = 0; i < 1024; i++) mem0.mem[i] = image[i];
    expect_pc = reset_pc;
    repeat (2) @(posedge clock);
    #10 reset = 1'b1;
    decode_formats();
    flag_illegal();
    walk_pc_sequence();
    redirect_mid_cycle();
    hold_with_halt();
    decode_random();
    $display("RESULT: PASS");
    $finish;
  end

endmodule

/* src.f */
common/decode_pkg.sv
src/fetch/fetch_unit.sv
src/decode/lane_decoder.sv
src/decode/decode_register.sv
src/decode_top.sv
bench/instr_mem_model.sv
bench/tb_decode_top.sv

/* Bender.yml */
package:
  name: decode_top

sources:
  - common/decode_pkg.sv
  - src/fetch/fetch_unit.sv
  - src/decode/lane_decoder.sv
  - src/decode/decode_register.sv
  - src/decode_top.sv
  - target: test
    files:
      - bench/instr_mem_model.sv
      - bench/tb_decode_top.sv
